/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module csa_calc_tb -o csa_sim \
	&& ./obj_dir/csa_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^No errors$" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
exit 0

/* source/csa_calc_logic.sv */
`timescale 1ns/1ps
`include "csa_params.svh"

module csa_calc_logic (
	input  logic                    clk,
	input  logic                    rst_n,
	csa_req_if.sink                 req_if,
	output logic                    ready_o,
	output logic [`CSA_BLOCK_W-1:0] block_o,
	output logic [`CSA_DATA_W-1:0]  in_o,
	output logic [`CSA_TIMES_W-1:0] times_o,
	output logic [`CSA_TIMES_W-1:0] times_start_o,
	output logic [`CSA_DATA_W-1:0]  out_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_RUN
	} state_e;

	state_e state_q;
	logic   ready_q;
	logic   load;
	logic   step;

	logic [`CSA_TIMES_W-1:0] remain_q;
	logic [`CSA_TIMES_W-1:0] round_idx_q;

	csa_pkg::csa_word_u load_word;
	csa_pkg::csa_word_u cur_word;

	// fields of the request in calculation
	logic [`CSA_BLOCK_W-1:0] blk_q;
	logic [`CSA_DATA_W-1:0]  in_q;
	logic [`CSA_TIMES_W-1:0] times_q;
	logic [`CSA_TIMES_W-1:0] tstart_q;

	// last result, held until the next ready
	logic [`CSA_BLOCK_W-1:0] blk_h;
	logic [`CSA_DATA_W-1:0]  in_h;
	logic [`CSA_TIMES_W-1:0] times_h;
	logic [`CSA_TIMES_W-1:0] tstart_h;
	logic [`CSA_DATA_W-1:0]  out_h;

	assign req_if.fifo_ren = (state_q == ST_IDLE) && req_if.fifo_ready;
	assign load = (state_q == ST_FETCH) && req_if.req_valid;
	assign step = (state_q == ST_RUN);
	assign load_word = req_if.req.data;

	csa_round_unit u_round (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_i      (load),
		.load_word_i (load_word),
		.step_i      (step),
		.round_idx_i (round_idx_q),
		.state_o     (cur_word)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			ready_q <= 1'b0;
			remain_q <= '0;
			round_idx_q <= '0;
		end else begin
			ready_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (req_if.fifo_ready) begin
						state_q <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					if (req_if.req_valid) begin
						remain_q <= req_if.req.times;
						round_idx_q <= req_if.req.times_start;
						// zero rounds, result is the loaded word
						if (req_if.req.times == '0) begin
							ready_q <= 1'b1;
							state_q <= ST_IDLE;
						end else begin
							state_q <= ST_RUN;
						end
					end
				end
				ST_RUN: begin
					remain_q <= remain_q - 1'b1;
					round_idx_q <= round_idx_q + 1'b1;
					if (remain_q == `CSA_TIMES_W'(1)) begin
						ready_q <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			blk_q <= req_if.req.block;
			in_q <= req_if.req.data;
			times_q <= req_if.req.times;
			tstart_q <= req_if.req.times_start;
		end
		if (ready_q) begin
			blk_h <= blk_q;
			in_h <= in_q;
			times_h <= times_q;
			tstart_h <= tstart_q;
			out_h <= cur_word;
		end
	end

	// live values on the ready cycle, held copy afterwards
	assign ready_o = ready_q;
	assign block_o = ready_q ? blk_q : blk_h;
	assign in_o = ready_q ? in_q : in_h;
	assign times_o = ready_q ? times_q : times_h;
	assign times_start_o = ready_q ? tstart_q : tstart_h;
	assign out_o = ready_q ? cur_word : out_h;

	a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		ready_o |=> !ready_o)
		else $error("ready_o longer than one cycle");

endmodule

/* source/csa_calc_top.sv */
`timescale 1ns/1ps
`include "csa_params.svh"

module csa_calc_top (
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    push_i,
	input  logic [`CSA_BLOCK_W-1:0] block_i,
	input  logic [`CSA_DATA_W-1:0]  in_i,
	input  logic [`CSA_TIMES_W-1:0] times_i,
	input  logic [`CSA_TIMES_W-1:0] times_start_i,
	output logic                    full_o,

	output logic                    ready_o,
	output logic [`CSA_BLOCK_W-1:0] block_o,
	output logic [`CSA_DATA_W-1:0]  in_o,
	output logic [`CSA_TIMES_W-1:0] times_o,
	output logic [`CSA_TIMES_W-1:0] times_start_o,
	output logic [`CSA_DATA_W-1:0]  out_o
);

	csa_pkg::csa_req_t push_req;

	csa_req_if u_req_if ();

	// request fields packed for the FIFO
	assign push_req = '{
		block:       block_i,
		data:        in_i,
		times:       times_i,
		times_start: times_start_i
	};

	csa_input_fifo u_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push_i     (push_i),
		.push_req_i (push_req),
		.full_o     (full_o),
		.req_if     (u_req_if.source)
	);

	csa_calc_logic u_calc (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_if        (u_req_if.sink),
		.ready_o       (ready_o),
		.block_o       (block_o),
		.in_o          (in_o),
		.times_o       (times_o),
		.times_start_o (times_start_o),
		.out_o         (out_o)
	);

endmodule

/* source/csa_input_fifo.sv */
`timescale 1ns/1ps
`include "csa_params.svh"

module csa_input_fifo (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              push_i,
	input  csa_pkg::csa_req_t push_req_i,
	output logic              full_o,
	csa_req_if.source         req_if
);

	localparam int DEPTH = `CSA_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	csa_pkg::csa_req_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_en;
	logic             rd_en;

	assign full_o = (count == CNT_W'(DEPTH));
	assign req_if.fifo_ready = (count != '0);

	// a push into a full FIFO is lost
	assign wr_en = push_i && !full_o;
	assign rd_en = req_if.fifo_ren && req_if.fifo_ready;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_req_i;
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		if (rd_en) begin
			req_if.req <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			req_if.req_valid <= 1'b0;
		end else begin
			req_if.req_valid <= rd_en;
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// consumer must wait for fifo_ready
	a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
		req_if.fifo_ren |-> req_if.fifo_ready)
		else $error("fifo_ren while FIFO empty");

	// producer must hold back on full_o
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		push_i |-> !full_o)
		else $error("push dropped, FIFO full");

endmodule

/* source/csa_params.svh */
`ifndef CSA_PARAMS_SVH
`define CSA_PARAMS_SVH

// block number carried with each request
`define CSA_BLOCK_W 32

// cypher word, eight bytes
`define CSA_DATA_W 64

// round count and start index
`define CSA_TIMES_W 8

// request FIFO entries, power of two
`define CSA_FIFO_DEPTH 4

`endif

/* source/csa_pkg.sv */
`include "csa_params.svh"

package csa_pkg;

	// one cypher word, seen as bytes or as two halves
	typedef union packed {
		logic [`CSA_DATA_W/8-1:0][7:0] bytes;
		struct packed {
			logic [`CSA_DATA_W/2-1:0] hi;
			logic [`CSA_DATA_W/2-1:0] lo;
		} half;
	} csa_word_u;

	// one queued calculation request
	typedef struct packed {
		logic [`CSA_BLOCK_W-1:0] block;
		logic [`CSA_DATA_W-1:0] data;
		logic [`CSA_TIMES_W-1:0] times;
		logic [`CSA_TIMES_W-1:0] times_start;
	} csa_req_t;

endpackage

/* source/csa_req_if.sv */
`timescale 1ns/1ps

interface csa_req_if;

	// FIFO not empty
	logic fifo_ready;
	// pop strobe, only while fifo_ready is high
	logic fifo_ren;
	csa_pkg::csa_req_t req;
	// marks req, one cycle after fifo_ren
	logic req_valid;

	modport source (
		output fifo_ready,
		output req,
		output req_valid,
		input  fifo_ren
	);

	modport sink (
		input  fifo_ready,
		input  req,
		input  req_valid,
		output fifo_ren
	);

endinterface

/* source/csa_round_unit.sv */
`timescale 1ns/1ps
`include "csa_params.svh"

module csa_round_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    load_i,
	input  csa_pkg::csa_word_u      load_word_i,
	input  logic                    step_i,
	input  logic [`CSA_TIMES_W-1:0] round_idx_i,
	output csa_pkg::csa_word_u      state_o
);

	localparam int HALF_W = `CSA_DATA_W / 2;
	localparam int NBYTES = `CSA_DATA_W / 8;

	csa_pkg::csa_word_u state_q;
	csa_pkg::csa_word_u sub;
	csa_pkg::csa_word_u nxt;

	// byte substitute, rotl by one then xor
	always_comb begin
		sub = '0;
		for (int i = 0; i < NBYTES; i++) begin
			sub.bytes[i] = {state_q.bytes[i][6:0], state_q.bytes[i][7]} ^ 8'h5a;
		end
	end

	// half swap and index mix
	always_comb begin
		nxt.half.lo = sub.half.hi;
		nxt.half.hi = (state_q.half.lo ^ sub.half.hi) + HALF_W'(round_idx_i);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= '0;
		end else if (load_i) begin
			state_q <= load_word_i;
		end else if (step_i) begin
			state_q <= nxt;
		end
	end

	assign state_o = state_q;

	// controller never loads and steps in one cycle
	a_load_step_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(load_i && step_i))
		else $error("load_i and step_i both high");

endmodule

/* tb.f */
+incdir+source
source/csa_pkg.sv
source/csa_req_if.sv
source/csa_input_fifo.sv
source/csa_round_unit.sv
source/csa_calc_logic.sv
source/csa_calc_top.sv
verification/csa_calc_tb.sv

/* verification/csa_calc_tb.sv */
`timescale 1ns/1ps
`include "csa_params.svh"

module csa_calc_tb;

	localparam int N_RAND = 40;
	localparam int N_REQ = N_RAND + 1;
	// worst case per request plus queueing and a margin for reset and drain
	localparam int WATCHDOG_CYCLES = N_REQ * (15 + 3 + `CSA_FIFO_DEPTH) + 200;

	logic                    clk;
	logic                    rst_n;
	logic                    push_i;
	logic [`CSA_BLOCK_W-1:0] block_i;
	logic [`CSA_DATA_W-1:0]  in_i;
	logic [`CSA_TIMES_W-1:0] times_i;
	logic [`CSA_TIMES_W-1:0] times_start_i;
	logic                    full_o;
	logic                    ready_o;
	logic [`CSA_BLOCK_W-1:0] block_o;
	logic [`CSA_DATA_W-1:0]  in_o;
	logic [`CSA_TIMES_W-1:0] times_o;
	logic [`CSA_TIMES_W-1:0] times_start_o;
	logic [`CSA_DATA_W-1:0]  out_o;

	csa_pkg::csa_req_t pending [$];
	logic [31:0] lfsr;
	int mismatch_count;
	int fail_count;
	int results_seen;
	logic saw_full;

	csa_calc_top u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.push_i        (push_i),
		.block_i       (block_i),
		.in_i          (in_i),
		.times_i       (times_i),
		.times_start_i (times_start_i),
		.full_o        (full_o),
		.ready_o       (ready_o),
		.block_o       (block_o),
		.in_o          (in_o),
		.times_o       (times_o),
		.times_start_o (times_start_o),
		.out_o         (out_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};
		end
	endtask

	// only the substituted high half feeds the next state
	function automatic logic [63:0] expected_out(input logic [63:0] word,
			input logic [7:0] times, input logic [7:0] start);
		logic [63:0] w;
		logic [31:0] sub_hi;
		logic [7:0]  b;
		logic [7:0]  idx;
		w = word;
		idx = start;
		for (int r = 0; r < times; r++) begin
			for (int i = 4; i < 8; i++) begin
				b = w[i*8 +: 8];
				sub_hi[(i-4)*8 +: 8] = {b[6:0], b[7]} ^ 8'h5a;
			end
			w = {(w[31:0] ^ sub_hi) + {24'h0, idx}, sub_hi};
			idx = idx + 8'd1;
		end
		return w;
	endfunction

	task automatic make_req(output csa_pkg::csa_req_t r);
		logic [63:0] v;
		take_bits(32, v);
		r.block = v[31:0];
		take_bits(64, v);
		r.data = v;
		take_bits(4, v);
		// keep 1 to 15
		r.times = (v[7:0] % 8'd15) + 8'd1;
		take_bits(8, v);
		r.times_start = v[7:0];
	endtask

	// called 1 ns after a rising edge and holds back on full_o
	task automatic send(input csa_pkg::csa_req_t r);
		while (full_o) begin
			saw_full = 1'b1;
			push_i = 1'b0;
			@(posedge clk);
			#1;
		end
		push_i = 1'b1;
		block_i = r.block;
		in_i = r.data;
		times_i = r.times;
		times_start_i = r.times_start;
		pending.push_back(r);
		@(posedge clk);
		#1;
	endtask

	always @(negedge clk) begin
		csa_pkg::csa_req_t exp;
		logic [63:0] exp_out;
		if (rst_n && full_o && pending.size() < `CSA_FIFO_DEPTH) begin
			$display("full_o high with only %0d requests outstanding", pending.size());
			fail_count++;
		end
		if (rst_n && ready_o) begin
			if (pending.size() == 0) begin
				$display("ready_o pulse with no request pending");
				fail_count++;
			end else begin
				exp = pending.pop_front();
				exp_out = expected_out(exp.data, exp.times, exp.times_start);
				results_seen++;
				if (block_o !== exp.block) begin
					$display("Mismatch block_o: got %h expected %h", block_o, exp.block);
					mismatch_count++;
				end
				if (in_o !== exp.data) begin
					$display("Mismatch in_o: got %h expected %h", in_o, exp.data);
					mismatch_count++;
				end
				if (times_o !== exp.times) begin
					$display("Mismatch times_o: got %h expected %h", times_o, exp.times);
					mismatch_count++;
				end
				if (times_start_o !== exp.times_start) begin
					$display("Mismatch times_start_o: got %h expected %h",
						times_start_o, exp.times_start);
					mismatch_count++;
				end
				if (out_o !== exp_out) begin
					$display("Mismatch out_o: got %h expected %h", out_o, exp_out);
					mismatch_count++;
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, %0d requests still pending",
			WATCHDOG_CYCLES, pending.size());
		$display("Errors found");
		$finish;
	end

	initial begin
		csa_pkg::csa_req_t r;
		rst_n = 1'b0;
		push_i = 1'b0;
		block_i = '0;
		in_i = '0;
		times_i = '0;
		times_start_i = '0;
		lfsr = 32'h99ed;
		mismatch_count = 0;
		fail_count = 0;
		results_seen = 0;
		saw_full = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		if (ready_o !== 1'b0 || full_o !== 1'b0) begin
			$display("ready_o or full_o not low after reset");
			fail_count++;
		end
		// comparator flags any stray ready_o while idle
		repeat (8) @(posedge clk);
		#1;

		// out must equal in with zero rounds
		make_req(r);
		r.times = '0;
		send(r);
		push_i = 1'b0;
		while (pending.size() != 0) begin
			@(posedge clk);
		end
		#1;

		// back to back random requests
		for (int n = 0; n < N_RAND; n++) begin
			make_req(r);
			send(r);
		end
		push_i = 1'b0;
		while (pending.size() != 0) begin
			@(posedge clk);
		end
		repeat (5) @(posedge clk);

		if (!saw_full) begin
			$display("full_o never rose during back to back pushes");
			fail_count++;
		end
		if (results_seen != N_REQ) begin
			$display("got %0d results for %0d requests", results_seen, N_REQ);
			fail_count++;
		end
		$display("done: %0d mismatches, %0d other errors", mismatch_count, fail_count);
		if (mismatch_count + fail_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
